/* source/mem_bus_pkg.sv */
// ----------------------------------------------------------
// memory bus field widths
// channel structs for AR/AW, W, R and B beats
// write response codes
// ----------------------------------------------------------
`default_nettype none

package mem_bus_pkg;

    // ----------------------------------------------------------
    // field widths
    // ----------------------------------------------------------
    localparam int unsigned addr_w = 32;
    localparam int unsigned data_w = 32;
    localparam int unsigned id_w   = 4;
    localparam int unsigned len_w  = 4;             // beats minus one
    localparam int unsigned strb_w = data_w / 8;    // one strobe per byte
    localparam int unsigned resp_w = 2;

    // write response codes
    typedef enum logic [resp_w-1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

    // ----------------------------------------------------------
    // channel beats
    // ----------------------------------------------------------

    // read or write address, same layout for AR and AW
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
    } addr_chan_t;

    // write data, no id on this bus
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } wdata_chan_t;

    // read data
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic              last;
    } rdata_chan_t;

    // write response, one per burst
    typedef struct packed {
        logic [id_w-1:0] id;
        resp_e           resp;
    } bresp_chan_t;

endpackage

`default_nettype wire

/* source/port_map_pkg.sv */
// ----------------------------------------------------------
// requester enumeration and ID map
// write-order FIFO sizing
// ----------------------------------------------------------
`default_nettype none

package port_map_pkg;

    localparam int unsigned n_req = 3;

    // index into every requester array
    typedef enum logic [1:0] {
        req_fetch  = 2'd0,
        req_bypass = 2'd1,
        req_refill = 2'd2
    } requester_e;

    // ----------------------------------------------------------
    // id map
    // ----------------------------------------------------------
    localparam logic [mem_bus_pkg::id_w-1:0] id_fetch       = 4'b0000;
    localparam logic [mem_bus_pkg::id_w-1:0] id_bypass_base = 4'b1000;  // 10xx
    localparam int unsigned                  id_bypass_lsb  = 2;        // low bits free
    localparam logic [mem_bus_pkg::id_w-1:0] id_refill      = 4'b1100;

    // outstanding write bursts
    localparam int unsigned w_fifo_depth = 4;
    localparam int unsigned w_fifo_ptr_w = $clog2(w_fifo_depth);

endpackage

`default_nettype wire

/* source/stream_arbiter.sv */
// ----------------------------------------------------------
// round-robin arbiter for one address channel
// grant is locked from first presentation until handshake
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module stream_arbiter (
    input  wire logic                                              clk_i,
    input  wire logic                                              rst_n_i,
    input  wire mem_bus_pkg::addr_chan_t [port_map_pkg::n_req-1:0] inp_chan_i,
    input  wire logic [port_map_pkg::n_req-1:0]                    inp_valid_i,
    output logic [port_map_pkg::n_req-1:0]                         inp_ready_o,
    output mem_bus_pkg::addr_chan_t                                oup_chan_o,
    output logic                                                   oup_valid_o,
    input  wire logic                                              oup_ready_i,
    input  wire logic                                              hold_i,
    output port_map_pkg::requester_e                               gnt_o
);

    port_map_pkg::requester_e last_q;   // last winner
    port_map_pkg::requester_e gnt_q;    // grant held under back-pressure
    logic                     lock_q;
    port_map_pkg::requester_e cand;
    port_map_pkg::requester_e pick;
    logic                     found;
    port_map_pkg::requester_e gnt;

    function automatic port_map_pkg::requester_e next_req(input port_map_pkg::requester_e cur);
        case (cur)
            port_map_pkg::req_fetch:  return port_map_pkg::req_bypass;
            port_map_pkg::req_bypass: return port_map_pkg::req_refill;
            default:                  return port_map_pkg::req_fetch;
        endcase
    endfunction

    // ----------------------------------------------------------
    // search starts one past the last winner
    // ----------------------------------------------------------
    always_comb begin
        cand  = last_q;
        pick  = last_q;
        found = 1'b0;
        for (int k = 0; k < port_map_pkg::n_req; k++) begin
            cand = next_req(cand);
            if (!found && inp_valid_i[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign gnt         = lock_q ? gnt_q : pick;
    assign oup_valid_o = lock_q ? inp_valid_i[gnt_q] : (found && !hold_i);  // hold blocks new grants
    assign oup_chan_o  = inp_chan_i[gnt];
    assign gnt_o       = gnt;

    always_comb begin
        inp_ready_o      = '0;
        inp_ready_o[gnt] = oup_valid_o && oup_ready_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q <= port_map_pkg::req_refill;  // fetch wins first
            gnt_q  <= port_map_pkg::req_fetch;
            lock_q <= 1'b0;
        end else if (oup_valid_o && oup_ready_i) begin
            last_q <= gnt;
            lock_q <= 1'b0;
        end else if (oup_valid_o) begin
            gnt_q  <= gnt;                       // stalled, keep this one
            lock_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/w_order_fifo.sv */
// ----------------------------------------------------------
// write-order FIFO
// records the owner of each accepted AW and steers that
// owner's W beats to the bus until the last beat
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module w_order_fifo (
    input  wire logic                                               clk_i,
    input  wire logic                                               rst_n_i,
    input  wire port_map_pkg::requester_e                           aw_owner_i,
    input  wire logic                                               aw_fire_i,
    output logic                                                    full_o,
    input  wire mem_bus_pkg::wdata_chan_t [port_map_pkg::n_req-1:0] inp_w_i,
    input  wire logic [port_map_pkg::n_req-1:0]                     inp_w_valid_i,
    output logic [port_map_pkg::n_req-1:0]                          inp_w_ready_o,
    output mem_bus_pkg::wdata_chan_t                                oup_w_o,
    output logic                                                    oup_w_valid_o,
    input  wire logic                                               oup_w_ready_i
);

    port_map_pkg::requester_e              owner_q [port_map_pkg::w_fifo_depth];
    logic [port_map_pkg::w_fifo_ptr_w-1:0] wr_ptr_q;
    logic [port_map_pkg::w_fifo_ptr_w-1:0] rd_ptr_q;
    logic [port_map_pkg::w_fifo_ptr_w:0]   count_q;
    logic                                  empty;
    logic                                  push;
    logic                                  pop;
    port_map_pkg::requester_e              head;

    assign empty  = (count_q == '0);
    assign full_o = (count_q == port_map_pkg::w_fifo_depth[port_map_pkg::w_fifo_ptr_w:0]);
    assign head   = owner_q[rd_ptr_q];

    // ----------------------------------------------------------
    // W steering
    // ----------------------------------------------------------
    assign oup_w_o       = empty ? '0 : inp_w_i[head];          // nothing selected when idle
    assign oup_w_valid_o = !empty && inp_w_valid_i[head];

    always_comb begin
        inp_w_ready_o = '0;
        if (!empty) begin
            inp_w_ready_o[head] = oup_w_ready_i;
        end
    end

    assign push = aw_fire_i && !full_o;
    assign pop  = oup_w_valid_o && oup_w_ready_i && oup_w_o.last;  // burst done

    // ----------------------------------------------------------
    // pointers and count
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // depth is a power of two
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // owner storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            owner_q[wr_ptr_q] <= aw_owner_i;
        end
    end

endmodule

`default_nettype wire

/* source/resp_router.sv */
// ----------------------------------------------------------
// response router for R or B
// decodes the returning ID and steers valid and ready
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module resp_router (
    input  wire logic [mem_bus_pkg::id_w-1:0]   inp_id_i,
    input  wire logic                           inp_valid_i,
    output logic                                inp_ready_o,
    output logic [port_map_pkg::n_req-1:0]      oup_valid_o,
    input  wire logic [port_map_pkg::n_req-1:0] oup_ready_i
);

    localparam int unsigned hi = mem_bus_pkg::id_w - 1;
    localparam int unsigned lo = port_map_pkg::id_bypass_lsb;

    port_map_pkg::requester_e sel;

    // ----------------------------------------------------------
    // id decode
    // ----------------------------------------------------------
    always_comb begin
        if (inp_id_i == port_map_pkg::id_fetch) begin
            sel = port_map_pkg::req_fetch;
        end else if (inp_id_i[hi:lo] == port_map_pkg::id_bypass_base[hi:lo]) begin
            sel = port_map_pkg::req_bypass;   // any of the four bypass ids
        end else begin
            // refill id and any unmapped id
            sel = port_map_pkg::req_refill;
        end
    end

    // steer valid out and take that port's ready back
    always_comb begin
        oup_valid_o      = '0;
        oup_valid_o[sel] = inp_valid_i;
    end

    assign inp_ready_o = oup_ready_i[sel];

endmodule

`default_nettype wire

/* source/mem_port_mux.sv */
// ----------------------------------------------------------
// memory port interconnect
// three requesters onto one memory port: AR/AW arbiters,
// W ordering FIFO, R/B routers
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_port_mux (
    input  wire logic                                               clk_i,
    input  wire logic                                               rst_n_i,
    // requester side, indexed by requester_e
    input  wire mem_bus_pkg::addr_chan_t  [port_map_pkg::n_req-1:0] req_ar_i,
    input  wire logic [port_map_pkg::n_req-1:0]                     req_ar_valid_i,
    output logic [port_map_pkg::n_req-1:0]                          req_ar_ready_o,
    input  wire mem_bus_pkg::addr_chan_t  [port_map_pkg::n_req-1:0] req_aw_i,
    input  wire logic [port_map_pkg::n_req-1:0]                     req_aw_valid_i,
    output logic [port_map_pkg::n_req-1:0]                          req_aw_ready_o,
    input  wire mem_bus_pkg::wdata_chan_t [port_map_pkg::n_req-1:0] req_w_i,
    input  wire logic [port_map_pkg::n_req-1:0]                     req_w_valid_i,
    output logic [port_map_pkg::n_req-1:0]                          req_w_ready_o,
    output mem_bus_pkg::rdata_chan_t [port_map_pkg::n_req-1:0]      req_r_o,
    output logic [port_map_pkg::n_req-1:0]                          req_r_valid_o,
    input  wire logic [port_map_pkg::n_req-1:0]                     req_r_ready_i,
    output mem_bus_pkg::bresp_chan_t [port_map_pkg::n_req-1:0]      req_b_o,
    output logic [port_map_pkg::n_req-1:0]                          req_b_valid_o,
    input  wire logic [port_map_pkg::n_req-1:0]                     req_b_ready_i,
    // memory side
    output mem_bus_pkg::addr_chan_t                                 mem_ar_o,
    output logic                                                    mem_ar_valid_o,
    input  wire logic                                               mem_ar_ready_i,
    output mem_bus_pkg::addr_chan_t                                 mem_aw_o,
    output logic                                                    mem_aw_valid_o,
    input  wire logic                                               mem_aw_ready_i,
    output mem_bus_pkg::wdata_chan_t                                mem_w_o,
    output logic                                                    mem_w_valid_o,
    input  wire logic                                               mem_w_ready_i,
    input  wire mem_bus_pkg::rdata_chan_t                           mem_r_i,
    input  wire logic                                               mem_r_valid_i,
    output logic                                                    mem_r_ready_o,
    input  wire mem_bus_pkg::bresp_chan_t                           mem_b_i,
    input  wire logic                                               mem_b_valid_i,
    output logic                                                    mem_b_ready_o
);

    logic                     aw_fire;
    logic                     w_full;
    port_map_pkg::requester_e aw_gnt;

    assign aw_fire = mem_aw_valid_o && mem_aw_ready_i;

    // ----------------------------------------------------------
    // address channels
    // ----------------------------------------------------------
    stream_arbiter i_ar_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .inp_chan_i  (req_ar_i),
        .inp_valid_i (req_ar_valid_i),
        .inp_ready_o (req_ar_ready_o),
        .oup_chan_o  (mem_ar_o),
        .oup_valid_o (mem_ar_valid_o),
        .oup_ready_i (mem_ar_ready_i),
        .hold_i      (1'b0),            // reads never stall here
        .gnt_o       ()
    );

    stream_arbiter i_aw_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .inp_chan_i  (req_aw_i),
        .inp_valid_i (req_aw_valid_i),
        .inp_ready_o (req_aw_ready_o),
        .oup_chan_o  (mem_aw_o),
        .oup_valid_o (mem_aw_valid_o),
        .oup_ready_i (mem_aw_ready_i),
        .hold_i      (w_full),          // no room to record another owner
        .gnt_o       (aw_gnt)
    );

    // ----------------------------------------------------------
    // write data follows AW acceptance order
    // ----------------------------------------------------------
    w_order_fifo i_w_order (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .aw_owner_i    (aw_gnt),
        .aw_fire_i     (aw_fire),
        .full_o        (w_full),
        .inp_w_i       (req_w_i),
        .inp_w_valid_i (req_w_valid_i),
        .inp_w_ready_o (req_w_ready_o),
        .oup_w_o       (mem_w_o),
        .oup_w_valid_o (mem_w_valid_o),
        .oup_w_ready_i (mem_w_ready_i)
    );

    // ----------------------------------------------------------
    // responses, payload to all, valid by id
    // ----------------------------------------------------------
    assign req_r_o = {port_map_pkg::n_req{mem_r_i}};
    assign req_b_o = {port_map_pkg::n_req{mem_b_i}};

    resp_router i_r_router (
        .inp_id_i    (mem_r_i.id),
        .inp_valid_i (mem_r_valid_i),
        .inp_ready_o (mem_r_ready_o),
        .oup_valid_o (req_r_valid_o),
        .oup_ready_i (req_r_ready_i)
    );

    resp_router i_b_router (
        .inp_id_i    (mem_b_i.id),
        .inp_valid_i (mem_b_valid_i),
        .inp_ready_o (mem_b_ready_o),
        .oup_valid_o (req_b_valid_o),
        .oup_ready_i (req_b_ready_i)
    );

endmodule

`default_nettype wire

/* test/tb_mem_port_mux.sv */
// ------------------------------------------------------------
// testbench for the memory port interconnect
// requester and memory models, random traffic, scoreboard
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_mem_port_mux;

    localparam int n           = int'(port_map_pkg::n_req);
    localparam int depth       = int'(port_map_pkg::w_fifo_depth);
    localparam int drive_delay = 10;

    // one outstanding burst as the memory side sees it
    typedef struct packed {
        port_map_pkg::requester_e      owner;
        logic [mem_bus_pkg::id_w-1:0]  id;
        logic [mem_bus_pkg::len_w-1:0] left;   // beats still due minus one
    } burst_t;

    logic clk_i = 1'b0;
    logic rst_n_i = 1'b0;
    mem_bus_pkg::addr_chan_t  [n-1:0] req_ar_i, req_aw_i;
    mem_bus_pkg::wdata_chan_t [n-1:0] req_w_i;
    mem_bus_pkg::rdata_chan_t [n-1:0] req_r_o;
    mem_bus_pkg::bresp_chan_t [n-1:0] req_b_o;
    logic [n-1:0] req_ar_valid_i, req_ar_ready_o, req_aw_valid_i, req_aw_ready_o;
    logic [n-1:0] req_w_valid_i, req_w_ready_o, req_r_valid_o, req_r_ready_i;
    logic [n-1:0] req_b_valid_o, req_b_ready_i;
    mem_bus_pkg::addr_chan_t  mem_ar_o, mem_aw_o;
    mem_bus_pkg::wdata_chan_t mem_w_o;
    mem_bus_pkg::rdata_chan_t mem_r_i;
    mem_bus_pkg::bresp_chan_t mem_b_i;
    logic mem_ar_valid_o, mem_ar_ready_i, mem_aw_valid_o, mem_aw_ready_i;
    logic mem_w_valid_o, mem_w_ready_i, mem_r_valid_i, mem_r_ready_o;
    logic mem_b_valid_i, mem_b_ready_o;

    // ------------------------------------------------------------
    // model state
    // ------------------------------------------------------------
    int seed = 74;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed_tests = 0;
    int rd_left [n], wr_left [n], r_exp [n], r_got [n], b_exp [n], b_got [n];
    int w_beat [n], gap [n];
    int w_todo [n][$];          // burst lengths issued per requester, oldest first
    burst_t rd_pend [$];
    burst_t w_order [$];        // accepted AWs in acceptance order
    logic [mem_bus_pkg::id_w-1:0] b_pend [$];
    int r_idx = -1;
    int ar_win = -1;
    int aw_win = -1;
    int w_win = -1;
    int aw_count = 0;
    logic r_fire = 1'b0;
    logic b_fire = 1'b0;
    logic fair_mode = 1'b0;
    logic stall_mode = 1'b0;
    logic hold_q [2] = '{1'b0, 1'b0};
    mem_bus_pkg::addr_chan_t hold_beat [2];

    mem_port_mux i_dut (.*);

    always #50 clk_i = ~clk_i;

    function automatic int rnd(input int span);
        return int'($unsigned($random(seed)) % span);
    endfunction

    function automatic logic [mem_bus_pkg::id_w-1:0] id_for(input int r);
        case (r)
            0:       return 4'b0000;
            1:       return 4'b1000 | 4'(rnd(4));  // any of 10xx
            default: return 4'b1100;
        endcase
    endfunction

    // id map: 0000 fetch, 10xx bypass, rest refill
    function automatic int owner_of(input logic [mem_bus_pkg::id_w-1:0] id);
        if (id == 4'b0000) return 0;
        if (id[3:2] == 2'b10) return 1;
        return 2;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic log_failure(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    // hold rule, source lookup and ready steering for AR or AW
    task automatic check_addr_channel(input int c, input string ch,
            input mem_bus_pkg::addr_chan_t beat, input logic vld, input logic rdy,
            input mem_bus_pkg::addr_chan_t [n-1:0] rq_beat, input logic [n-1:0] rq_vld,
            input logic [n-1:0] rq_rdy, output int win);
        int src;
        src = -1;
        win = -1;
        if (hold_q[c]) begin
            check_value({ch, "_valid_o held"}, 64'(vld), 64'd1);
            check_value({ch, "_o held"}, 64'(beat), 64'(hold_beat[c]));
        end
        hold_q[c]    = vld && !rdy;
        hold_beat[c] = beat;
        for (int r = 0; r < n; r++) begin
            if (vld && rq_vld[r] && rq_beat[r] == beat) src = r;   // ids differ per requester
        end
        if (vld && src < 0) log_failure({ch, " beat on memory port matches no requester beat"});
        if (vld && rdy && src >= 0) begin
            win = src;
            check_value({ch, " requester ready"}, 64'(rq_rdy), 64'(1 << src));
        end else begin
            check_value({ch, " requester ready"}, 64'(rq_rdy), 64'd0);
        end
    endtask

    // ------------------------------------------------------------
    // sampling at the falling edge, values settled for the next rise
    // ------------------------------------------------------------
    task automatic sample_bus();
        burst_t b;
        int o;
        int e;
        check_addr_channel(0, "mem_ar", mem_ar_o, mem_ar_valid_o, mem_ar_ready_i,
                           req_ar_i, req_ar_valid_i, req_ar_ready_o, ar_win);
        if (ar_win >= 0) begin
            b = '{port_map_pkg::requester_e'(ar_win), mem_ar_o.id, mem_ar_o.len};
            rd_pend.push_back(b);
        end
        if (fair_mode && ar_win >= 0 && &req_ar_valid_i) begin
            for (int r = 0; r < n; r++) begin
                gap[r] = (r == ar_win) ? 0 : gap[r] + 1;
                if (gap[r] > 2) log_failure($sformatf("requester %0d passed over more than twice", r));
            end
        end
        // W before AW, a new owner is visible one cycle later
        o = (w_order.size() > 0) ? int'(w_order[0].owner) : -1;
        if (o < 0) begin
            if (mem_w_valid_o) log_failure("W beat on memory port without an accepted AW");
            check_value("req_w_ready_o", 64'(req_w_ready_o), 64'd0);
        end else begin
            check_value("mem_w_valid_o", 64'(mem_w_valid_o), 64'(req_w_valid_i[o]));
            check_value("req_w_ready_o", 64'(req_w_ready_o), 64'(mem_w_ready_i) << o);
            if (mem_w_valid_o) begin
                check_value("mem_w_o", 64'(mem_w_o), 64'(req_w_i[o]));
                check_value("mem_w_o.last", 64'(mem_w_o.last), 64'(w_order[0].left == 0));
            end
            if (mem_w_valid_o && mem_w_ready_i) begin
                w_win = o;
                b = w_order.pop_front();
                if (b.left == 0) begin
                    b_pend.push_back(b.id);   // burst done, memory owes a B
                end else begin
                    b.left = b.left - 4'd1;
                    w_order.push_front(b);
                end
            end
        end
        check_addr_channel(1, "mem_aw", mem_aw_o, mem_aw_valid_o, mem_aw_ready_i,
                           req_aw_i, req_aw_valid_i, req_aw_ready_o, aw_win);
        if (aw_win >= 0) begin
            b = '{port_map_pkg::requester_e'(aw_win), mem_aw_o.id, mem_aw_o.len};
            w_order.push_back(b);
            aw_count++;
            if (w_order.size() > depth) log_failure("more write bursts accepted than the FIFO holds");
        end
        // responses
        e = owner_of(mem_r_i.id);
        check_value("req_r_valid_o", 64'(req_r_valid_o), mem_r_valid_i ? 64'(1 << e) : 64'd0);
        if (mem_r_valid_i) begin
            check_value("req_r_o", 64'(req_r_o[e]), 64'(mem_r_i));
            check_value("mem_r_ready_o", 64'(mem_r_ready_o), 64'(req_r_ready_i[e]));
            r_fire = req_r_ready_i[e];
            r_got[e] += int'(r_fire);
        end
        e = owner_of(mem_b_i.id);
        check_value("req_b_valid_o", 64'(req_b_valid_o), mem_b_valid_i ? 64'(1 << e) : 64'd0);
        if (mem_b_valid_i) begin
            check_value("req_b_o", 64'(req_b_o[e]), 64'(mem_b_i));
            check_value("mem_b_ready_o", 64'(mem_b_ready_o), 64'(req_b_ready_i[e]));
            b_fire = req_b_ready_i[e];
            b_got[e] += int'(b_fire);
        end
    endtask

    // ------------------------------------------------------------
    // requester and memory models, driven after the rising edge
    // ------------------------------------------------------------
    task automatic drive_inputs();
        burst_t b;
        int idx;
        for (int r = 0; r < n; r++) begin
            if (ar_win == r) req_ar_valid_i[r] = 1'b0;
            if (!req_ar_valid_i[r] && rd_left[r] > 0 && (fair_mode || rnd(3) == 0)) begin
                req_ar_i[r] = '{id_for(r), $random(seed), 4'(rnd(4))};
                req_ar_valid_i[r] = 1'b1;
                rd_left[r]--;
                r_exp[r] += int'(req_ar_i[r].len) + 1;
            end
            if (aw_win == r) req_aw_valid_i[r] = 1'b0;
            if (!req_aw_valid_i[r] && wr_left[r] > 0 && (stall_mode || rnd(3) == 0)) begin
                req_aw_i[r] = '{id_for(r), $random(seed), 4'(rnd(4))};
                req_aw_valid_i[r] = 1'b1;
                wr_left[r]--;
                b_exp[r]++;
                w_todo[r].push_back(int'(req_aw_i[r].len));
            end
            if (w_win == r) begin
                req_w_valid_i[r] = 1'b0;
                w_beat[r] = req_w_i[r].last ? 0 : w_beat[r] + 1;
                if (req_w_i[r].last) void'(w_todo[r].pop_front());
            end
            if (!req_w_valid_i[r] && w_todo[r].size() > 0 && rnd(4) != 0) begin
                req_w_i[r] = '{$random(seed), 4'(rnd(16)), w_beat[r] == w_todo[r][0]};
                req_w_valid_i[r] = 1'b1;
            end
            req_r_ready_i[r] = (rnd(4) != 0);
            req_b_ready_i[r] = (rnd(4) != 0);
        end
        mem_ar_ready_i = (rnd(2) != 0);
        mem_aw_ready_i = stall_mode || (rnd(2) != 0);
        mem_w_ready_i  = !stall_mode && (rnd(2) != 0);
        if (r_fire) begin
            b = rd_pend[r_idx];
            mem_r_valid_i = 1'b0;
            if (b.left == 0) begin
                rd_pend.delete(r_idx);
                r_idx = -1;
            end else begin
                b.left = b.left - 4'd1;
                rd_pend[r_idx] = b;
            end
        end
        if (!mem_r_valid_i && rd_pend.size() > 0 && rnd(2) != 0) begin
            if (r_idx < 0) r_idx = rnd(rd_pend.size());   // next burst picked at random
            mem_r_i = '{rd_pend[r_idx].id, $random(seed), rd_pend[r_idx].left == 0};
            mem_r_valid_i = 1'b1;
        end
        if (b_fire) mem_b_valid_i = 1'b0;
        if (!mem_b_valid_i && b_pend.size() > 0 && rnd(2) != 0) begin
            idx = rnd(b_pend.size());
            mem_b_i = '{b_pend[idx], mem_bus_pkg::resp_okay};
            b_pend.delete(idx);
            mem_b_valid_i = 1'b1;
        end
        ar_win = -1;
        aw_win = -1;
        w_win  = -1;
        r_fire = 1'b0;
        b_fire = 1'b0;
    endtask

    always @(negedge clk_i) if (rst_n_i) sample_bus();

    always @(posedge clk_i) begin
        #drive_delay;
        drive_inputs();
    end

    function automatic logic traffic_done();
        logic busy;
        busy = rd_pend.size() > 0 || w_order.size() > 0 || b_pend.size() > 0;
        busy = busy || mem_r_valid_i || mem_b_valid_i;
        for (int r = 0; r < n; r++) begin
            busy = busy || rd_left[r] > 0 || wr_left[r] > 0 || w_todo[r].size() > 0;
            busy = busy || req_ar_valid_i[r] || req_aw_valid_i[r];
        end
        return !busy;
    endfunction

    task automatic wait_drained(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (!traffic_done() && cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!traffic_done()) log_failure({"timeout waiting for ", name, " traffic to drain"});
        for (int r = 0; r < n; r++) begin
            check_value($sformatf("R beats at requester %0d", r), 64'(r_got[r]), 64'(r_exp[r]));
            check_value($sformatf("B beats at requester %0d", r), 64'(b_got[r]), 64'(b_exp[r]));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %-16s ok", name);
        end else begin
            failed_tests++;
            $display("test %-16s FAILED, %0d errors", name, errors - errs_before);
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        int e0;
        int cycles;
        {req_ar_i, req_aw_i, req_w_i} = '0;
        {req_ar_valid_i, req_aw_valid_i, req_w_valid_i, req_r_ready_i, req_b_ready_i} = '0;
        {mem_r_i, mem_b_i} = '0;
        {mem_ar_ready_i, mem_aw_ready_i, mem_w_ready_i, mem_r_valid_i, mem_b_valid_i} = '0;
        for (int r = 0; r < n; r++) begin
            {rd_left[r], wr_left[r], r_exp[r], r_got[r], b_exp[r], b_got[r]} = '0;
            {w_beat[r], gap[r]} = '0;
        end
        repeat (5) @(posedge clk_i);
        #drive_delay rst_n_i = 1'b1;

        e0 = errors;
        for (int r = 0; r < n; r++) begin
            rd_left[r] = 24;
            wr_left[r] = (r == 0) ? 0 : 16;   // fetch only reads
        end
        wait_drained("random", 4000);
        report_test("random traffic", e0);

        e0 = errors;
        fair_mode = 1'b1;
        for (int r = 0; r < n; r++) rd_left[r] = 30;
        wait_drained("fairness", 3000);
        fair_mode = 1'b0;
        report_test("ar fairness", e0);

        // W held off, AW ready high, only depth bursts fit
        e0 = errors;
        stall_mode = 1'b1;
        aw_count = 0;
        wr_left[1] = 4;
        wr_left[2] = 4;
        cycles = 0;
        while (aw_count < depth && cycles < 200) begin
            @(posedge clk_i);
            cycles++;
        end
        if (aw_count < depth) log_failure("timeout waiting for AWs under W stall");
        repeat (20) @(posedge clk_i);
        check_value("AW accepted with W stalled", 64'(aw_count), 64'(depth));
        stall_mode = 1'b0;
        wait_drained("w stall", 2000);
        report_test("w stall", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/mem_bus_pkg.sv
source/port_map_pkg.sv
source/stream_arbiter.sv
source/w_order_fifo.sv
source/resp_router.sv
source/mem_port_mux.sv
test/tb_mem_port_mux.sv

/* Makefile */
# Verilator build and regression run for the memory port interconnect

SIM := obj_dir/Vtb_mem_port_mux

.PHONY: all run clean

all: run

$(SIM): list.f $(wildcard source/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing -Wno-fatal --top-module tb_mem_port_mux -Mdir obj_dir -f list.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
